// ==== iqLevelPkg.sv ====
/* I/Q level detector shared types */

package iqLevelPkg;

    // I and Q width, two's complement
    localparam int sampleWidth = 18;

    // Magnitude and window average width, unsigned
    localparam int magWidth = 16;

    // Weights are Q17, so 17 bits hold either one
    localparam int weightWidth = 17;

    // Alpha-max plus beta-min, minimum peak error weights
    // alpha = 0.9604 * 2^17
    localparam logic [weightWidth-1:0] maxWeight = 17'd125886;
    // beta = 0.3978 * 2^17
    localparam logic [weightWidth-1:0] minWeight = 17'd52144;

    // One complex baseband sample
    typedef struct packed {
        logic signed [sampleWidth-1:0] i;
        logic signed [sampleWidth-1:0] q;
    } iqSample;

    // Detector FSM states
    typedef enum logic [1:0] {
        searching = 2'd0,
        acquiring = 2'd1,
        present   = 2'd2
    } detState;

    // Detector status as seen at the top level
    typedef struct packed {
        detState     state;
        logic        signalPresent;
        logic [7:0]  lockCount;
    } detStatus;

endpackage

// ==== complexMagEstimate.sv ====
/* Alpha-max plus beta-min magnitude */

`timescale 1ns/1ps

module complexMagEstimate
    import iqLevelPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  iqSample             sample,
    output logic [magWidth-1:0] mag,
    output logic                magValid
);

    // Absolute values keep 17 bits, so the most negative code wraps to zero
    localparam int absWidth  = sampleWidth - 1;
    localparam int prodWidth = absWidth + weightWidth;
    // Q17 weight times 17-bit value, scaled down to a 16-bit magnitude
    localparam int prodShift = prodWidth - magWidth;

    logic [absWidth-1:0]  absI;
    logic [absWidth-1:0]  absQ;
    logic [absWidth-1:0]  maxAbs;
    logic [absWidth-1:0]  minAbs;
    logic [prodWidth-1:0] maxProd;
    logic [prodWidth-1:0] minProd;
    logic [magWidth:0]    magSum;
    logic                 valid1;
    logic                 valid2;

    // Negate and truncate to the low 17 bits
    assign absI = sample.i[sampleWidth-1] ? absWidth'(-sample.i) : absWidth'(sample.i);
    assign absQ = sample.q[sampleWidth-1] ? absWidth'(-sample.q) : absWidth'(sample.q);

    // Stage one
    // Sort into larger and smaller
    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (absI > absQ) begin
                maxAbs <= absI;
                minAbs <= absQ;
            end else begin
                maxAbs <= absQ;
                minAbs <= absI;
            end
        end
    end

    // Stage two
    // Weighted products, both registered
    always_ff @(posedge clk) begin
        if (clkEn) begin
            maxProd <= maxAbs * maxWeight;
            minProd <= minAbs * minWeight;
        end
    end

    // Integer parts of both terms, one spare bit for overflow
    assign magSum = {1'b0, maxProd[prodWidth-1:prodShift]}
                  + {1'b0, minProd[prodWidth-1:prodShift]};

    // Stage three
    // Saturate at full scale
    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (magSum[magWidth]) begin
                mag <= '1;
            end else begin
                mag <= magSum[magWidth-1:0];
            end
        end
    end

    // Valid bits shift with the data on each strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            valid1   <= 1'b0;
            valid2   <= 1'b0;
            magValid <= 1'b0;
        end else begin
            if (clkEn) begin
                // Every strobe carries a new sample
                valid1 <= 1'b1;
                valid2 <= valid1;
            end
            // One clock per new result, mag holds afterwards
            magValid <= clkEn & valid2;
        end
    end

endmodule

// ==== windowTimer.sv ====
/* Averaging window timer */

`timescale 1ns/1ps

module windowTimer #(
    parameter int windowLog2 = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic magValid,
    output logic windowDone
);

    // Counts valid magnitudes within the current window
    logic [windowLog2-1:0] sampleCount;

    // Last sample of the window arrives when the count is all ones
    assign windowDone = magValid && (sampleCount == '1);

    // Wraps back to zero after the final sample
    always_ff @(posedge clk) begin
        if (reset) begin
            sampleCount <= '0;
        end else if (magValid) begin
            sampleCount <= sampleCount + 1'b1;
        end
    end

endmodule

// ==== magAccumulator.sv ====
/* Window magnitude averager */

`timescale 1ns/1ps

module magAccumulator
    import iqLevelPkg::*;
#(
    parameter int windowLog2 = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                magValid,
    input  logic                windowDone,
    input  logic [magWidth-1:0] mag,
    output logic [magWidth-1:0] avgMag,
    output logic                avgValid
);

    // Room for a full window of full-scale magnitudes
    localparam int sumWidth = magWidth + windowLog2;

    logic [sumWidth-1:0] magSum;
    logic [sumWidth-1:0] nextSum;

    // Running sum including the current sample
    assign nextSum = magSum + sumWidth'(mag);

    // Sum register, cleared at each window end
    always_ff @(posedge clk) begin
        if (reset) begin
            magSum <= '0;
        end else if (windowDone) begin
            magSum <= '0;
        end else if (magValid) begin
            magSum <= nextSum;
        end
    end

    // Power-of-two division is just the upper bits
    always_ff @(posedge clk) begin
        if (windowDone) begin
            avgMag <= nextSum[sumWidth-1:windowLog2];
        end
    end

    // One-clock strobe alongside the new average
    always_ff @(posedge clk) begin
        if (reset) begin
            avgValid <= 1'b0;
        end else begin
            avgValid <= windowDone;
        end
    end

endmodule

// ==== signalDetectFsm.sv ====
/* Signal presence detector */

`timescale 1ns/1ps

module signalDetectFsm
    import iqLevelPkg::*;
#(
    parameter int lockWindows = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                avgValid,
    input  logic [magWidth-1:0] avgMag,
    input  logic [magWidth-1:0] onThreshold,
    input  logic [magWidth-1:0] offThreshold,
    output detStatus            status
);

    // Consecutive windows needed for lock, at lockCount width
    localparam logic [7:0] lockTarget = 8'(lockWindows);

    detStatus statusNext;
    logic     aboveOn;
    logic     belowOff;
    logic [7:0] countInc;

    // Strict compares on both sides
    assign aboveOn  = avgMag > onThreshold;
    assign belowOff = avgMag < offThreshold;
    assign countInc = status.lockCount + 1'b1;

    always_comb begin
        statusNext = status;
        // Only a new window average moves the FSM
        if (avgValid) begin
            case (status.state)
                searching: begin
                    if (aboveOn) begin
                        statusNext.lockCount = 8'd1;
                        // Single-window lock skips acquiring
                        if (lockTarget == 8'd1) begin
                            statusNext.state         = present;
                            statusNext.signalPresent = 1'b1;
                        end else begin
                            statusNext.state = acquiring;
                        end
                    end
                end
                acquiring: begin
                    if (aboveOn) begin
                        statusNext.lockCount = countInc;
                        if (countInc == lockTarget) begin
                            statusNext.state         = present;
                            statusNext.signalPresent = 1'b1;
                        end
                    end else begin
                        // Run broken, start counting again
                        statusNext.state     = searching;
                        statusNext.lockCount = 8'd0;
                    end
                end
                present: begin
                    // Between the thresholds the flag holds
                    if (belowOff) begin
                        statusNext.state         = searching;
                        statusNext.signalPresent = 1'b0;
                        statusNext.lockCount     = 8'd0;
                    end
                end
                default: begin
                    statusNext.state         = searching;
                    statusNext.signalPresent = 1'b0;
                    statusNext.lockCount     = 8'd0;
                end
            endcase
        end
    end

    // Status updates one clock after avgValid
    always_ff @(posedge clk) begin
        if (reset) begin
            status.state         <= searching;
            status.signalPresent <= 1'b0;
            status.lockCount     <= 8'd0;
        end else begin
            status <= statusNext;
        end
    end

endmodule

// ==== iqLevelDetector.sv ====
/* I/Q signal level detector */

`timescale 1ns/1ps

module iqLevelDetector
    import iqLevelPkg::*;
#(
    parameter int windowLog2  = 4,
    parameter int lockWindows = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                clkEn,
    input  iqSample             sample,
    input  logic [magWidth-1:0] onThreshold,
    input  logic [magWidth-1:0] offThreshold,
    output logic [magWidth-1:0] mag,
    output logic                magValid,
    output logic [magWidth-1:0] avgMag,
    output logic                avgValid,
    output detStatus            status
);

    // Final sample of each window
    logic windowDone;

    // Per-sample magnitude, three strobes of latency
    complexMagEstimate magEst (
        .clk      (clk),
        .reset    (reset),
        .clkEn    (clkEn),
        .sample   (sample),
        .mag      (mag),
        .magValid (magValid)
    );

    // Decides window boundaries
    windowTimer #(
        .windowLog2 (windowLog2)
    ) winTimer (
        .clk        (clk),
        .reset      (reset),
        .magValid   (magValid),
        .windowDone (windowDone)
    );

    // Window sum and average
    magAccumulator #(
        .windowLog2 (windowLog2)
    ) magAcc (
        .clk        (clk),
        .reset      (reset),
        .magValid   (magValid),
        .windowDone (windowDone),
        .mag        (mag),
        .avgMag     (avgMag),
        .avgValid   (avgValid)
    );

    // Presence decision with hysteresis
    signalDetectFsm #(
        .lockWindows (lockWindows)
    ) detFsm (
        .clk          (clk),
        .reset        (reset),
        .avgValid     (avgValid),
        .avgMag       (avgMag),
        .onThreshold  (onThreshold),
        .offThreshold (offThreshold),
        .status       (status)
    );

endmodule

// ==== tb_iqLevelDetector.sv ====
/* I/Q level detector testbench */

`timescale 1ns/1ps

module tb_iqLevelDetector
    import iqLevelPkg::*;
();

    localparam int windowLen = 16;
    localparam int lockWindowsTb = 3;
    // Strobes over all tests including the two flush strobes
    localparam int totalSamples = 200 + 8 + 64 + 202 + 160 + 2;
    localparam int timeoutCycles = totalSamples * 4 + 200;

    logic clk = 1'b0;
    logic reset;
    logic clkEn;
    iqSample sample;
    logic [magWidth-1:0] onThreshold;
    logic [magWidth-1:0] offThreshold;
    logic [magWidth-1:0] mag;
    logic magValid;
    logic [magWidth-1:0] avgMag;
    logic avgValid;
    detStatus status;

    integer seed = 32'h7471;
    int errorCount = 0;
    int cycleCount = 0;
    int magChecks = 0;
    int avgChecks = 0;
    // Expected magnitudes in strobe order
    logic [magWidth-1:0] expQ[$];
    logic [magWidth-1:0] expMag;
    logic [magWidth-1:0] expAvg;
    bit avgPending = 1'b0;
    int winSum = 0;
    int winCount = 0;
    detStatus modelStatus = '{searching, 1'b0, 8'd0};

    iqLevelDetector DUT (.*);

    always #5 clk = ~clk;

    // Alpha-max plus beta-min with Q17 weights and saturation to 16 bits
    function automatic logic [magWidth-1:0] refMag(input iqSample s);
        logic [16:0] a;
        logic [16:0] b;
        longint hi;
        longint lo;
        longint sum;
        // Low 17 bits only, so -131072 becomes zero
        a = s.i[17] ? 17'(-s.i) : 17'(s.i);
        b = s.q[17] ? 17'(-s.q) : 17'(s.q);
        hi = (a > b) ? a : b;
        lo = (a > b) ? b : a;
        sum = ((hi * 125886) >> 18) + ((lo * 52144) >> 18);
        return (sum > 65535) ? 16'hFFFF : sum[15:0];
    endfunction

    // Hysteresis detector model stepped once per window average
    task automatic updateModel(input logic [magWidth-1:0] avg);
        case (modelStatus.state)
            searching: begin
                if (avg > onThreshold) begin
                    modelStatus.lockCount = 8'd1;
                    modelStatus.state = (lockWindowsTb == 1) ? present : acquiring;
                    modelStatus.signalPresent = (lockWindowsTb == 1);
                end
            end
            acquiring: begin
                if (avg > onThreshold) begin
                    modelStatus.lockCount++;
                    if (modelStatus.lockCount == lockWindowsTb) begin
                        modelStatus.state = present;
                        modelStatus.signalPresent = 1'b1;
                    end
                end else begin
                    modelStatus = '{searching, 1'b0, 8'd0};
                end
            end
            default: begin
                if (avg < offThreshold) modelStatus = '{searching, 1'b0, 8'd0};
            end
        endcase
    endtask

    task automatic reportFailure(input string msg);
        $display("error at %0t: %s", $time, msg);
        errorCount++;
    endtask

    task automatic checkMag(input logic [magWidth-1:0] got, input logic [magWidth-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkStatus(input detStatus got, input detStatus exp);
        if (got !== exp) begin
            $display("mismatch at %0t: status %s/%b/%0d, expected %s/%b/%0d", $time,
                     got.state.name(), got.signalPresent, got.lockCount,
                     exp.state.name(), exp.signalPresent, exp.lockCount);
            errorCount++;
        end
    endtask

    // End-of-phase state and its presence flag
    task automatic checkState(input detState exp);
        @(negedge clk);
        if (status.state !== exp || status.signalPresent !== (exp == present)) begin
            $display("mismatch at %0t: state %s, expected %s", $time, status.state.name(),
                     exp.name());
            errorCount++;
        end
    endtask

    task automatic driveSample(input logic signed [sampleWidth-1:0] i,
                               input logic signed [sampleWidth-1:0] q, input bit push);
        iqSample s;
        s.i = i;
        s.q = q;
        @(posedge clk);
        clkEn <= 1'b1;
        sample <= s;
        if (push) expQ.push_back(refMag(s));
    endtask

    // Stop strobing and let the last result out
    // Outstanding samples stay in stages one and two
    task automatic endPhase(input int outstanding);
        @(posedge clk);
        clkEn <= 1'b0;
        repeat (2) @(posedge clk);
        if (expQ.size() != outstanding)
            reportFailure($sformatf("%0d results outstanding instead of %0d", expQ.size(),
                                    outstanding));
    endtask

    task automatic drivePhase(input logic signed [sampleWidth-1:0] i,
                              input logic signed [sampleWidth-1:0] q, input int n);
        repeat (n) driveSample(i, q, 1'b1);
        endPhase(2);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        $display("test %s: %s, %0d errors", name, (errorCount == startErrors) ? "ok" : "failed",
                 errorCount - startErrors);
    endtask

    // Falling-edge compare of status, averages and magnitudes
    always @(negedge clk) begin
        if (!reset) begin
            checkStatus(status, modelStatus);
            if (avgValid) begin
                if (!avgPending) begin
                    reportFailure("avgValid pulsed without a completed window");
                end else begin
                    checkMag(avgMag, expAvg, "avgMag");
                    avgChecks++;
                    updateModel(expAvg);
                end
                avgPending = 1'b0;
            end
            if (magValid) begin
                if (expQ.size() == 0) begin
                    reportFailure("magValid pulsed with no sample outstanding");
                end else begin
                    expMag = expQ.pop_front();
                    checkMag(mag, expMag, "mag");
                    magChecks++;
                    winSum += expMag;
                    winCount++;
                    if (winCount == windowLen) begin
                        if (avgPending) reportFailure("previous window average never appeared");
                        expAvg = 16'(winSum >> 4);
                        avgPending = 1'b1;
                        winSum = 0;
                        winCount = 0;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout after %0d cycles, the run did not finish", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int startErrors;
        int startAvg;
        int strobes;
        logic [31:0] coin;
        logic [31:0] ri;
        logic [31:0] rq;
        reset = 1'b1;
        clkEn = 1'b0;
        sample = '0;
        onThreshold = 16'd20000;
        offThreshold = 16'd8000;

        // Reset holds all strobes low
        startErrors = errorCount;
        repeat (5) @(posedge clk);
        @(negedge clk);
        if (magValid !== 1'b0 || avgValid !== 1'b0) reportFailure("strobe high during reset");
        checkStatus(status, modelStatus);
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (magValid !== 1'b0 || avgValid !== 1'b0) reportFailure("strobe high after reset");
        reportTest("reset", startErrors);

        // Random samples with random gaps in clkEn
        startErrors = errorCount;
        strobes = 0;
        while (strobes < 200) begin
            coin = $random(seed);
            if (coin[0]) begin
                ri = $random(seed);
                rq = $random(seed);
                // Most negative code on each axis
                if (strobes == 37) ri = 32'h20000;
                if (strobes == 91) rq = 32'h20000;
                driveSample(ri[17:0], rq[17:0], 1'b1);
                strobes++;
            end else begin
                @(posedge clk);
                clkEn <= 1'b0;
            end
        end
        endPhase(2);
        reportTest("random magnitudes", startErrors);

        // Full scale, zero and single axis
        startErrors = errorCount;
        driveSample(18'sd131071, 18'sd131071, 1'b1);
        driveSample(-18'sd131071, 18'sd131071, 1'b1);
        driveSample(-18'sd131071, -18'sd131071, 1'b1);
        driveSample(18'sh20000, 18'sh20000, 1'b1);
        driveSample(18'sd0, 18'sd0, 1'b1);
        driveSample(18'sd131071, 18'sd0, 1'b1);
        driveSample(18'sd0, -18'sd131071, 1'b1);
        driveSample(18'sd1000, -18'sd2000, 1'b1);
        endPhase(2);
        reportTest("saturation and extremes", startErrors);

        // Four full windows of continuous random data
        startErrors = errorCount;
        startAvg = avgChecks;
        repeat (64) begin
            ri = $random(seed);
            rq = $random(seed);
            driveSample(ri[17:0], rq[17:0], 1'b1);
        end
        endPhase(2);
        if (avgChecks - startAvg != 4) reportFailure("wrong number of window averages");
        reportTest("window average", startErrors);

        // Short run breaks off, long run locks
        startErrors = errorCount;
        drivePhase(18'sd1000, 18'sd1000, 48);
        checkState(searching);
        drivePhase(18'sd60000, 18'sd60000, 26);
        checkState(acquiring);
        drivePhase(18'sd1000, 18'sd1000, 48);
        checkState(searching);
        drivePhase(18'sd60000, 18'sd60000, 80);
        checkState(present);
        reportTest("lock", startErrors);

        // Mid level sits between the thresholds
        startErrors = errorCount;
        drivePhase(18'sd20000, 18'sd0, 80);
        checkState(present);
        drivePhase(18'sd1000, 18'sd1000, 80);
        checkState(searching);
        reportTest("hysteresis and release", startErrors);

        // Flush the last two samples out
        driveSample(18'sd0, 18'sd0, 1'b0);
        driveSample(18'sd0, 18'sd0, 1'b0);
        endPhase(0);
        if (avgPending) reportFailure("last window average never appeared");

        $display("checked %0d magnitudes and %0d averages, %0d errors", magChecks, avgChecks,
                 errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== iqLevelDetector.f ====
iqLevelPkg.sv
complexMagEstimate.sv
windowTimer.sv
magAccumulator.sv
signalDetectFsm.sv
iqLevelDetector.sv
tb_iqLevelDetector.sv
